//--- hdl/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

////////////////////////////////////////////////////////////
// register addresses
////////////////////////////////////////////////////////////
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TID         14'h040
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

////////////////////////////////////////////////////////////
// field positions
////////////////////////////////////////////////////////////
`define CRMD_PLV        1:0
`define CRMD_IE         2
`define PRMD_PPLV       1:0
`define PRMD_PIE        2
// bit 10 of lie is reserved
`define ECFG_LIE        12:0
`define ESTAT_IS        12:0
`define ESTAT_ECODE     21:16
`define ESTAT_ESUBCODE  30:22
`define EENTRY_VA       31:6
`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITVAL    31:2
`define TICLR_CLR       0

// timer interrupt position in is
`define CSR_IS_TI       11

// writable bits, everything else reads zero
`define CSR_CRMD_WMASK      32'h0000_0007
`define CSR_ECFG_WMASK      32'h0000_1bff
`define CSR_ESTAT_WMASK     32'h0000_0003
`define CSR_EENTRY_WMASK    32'hffff_ffc0

`endif

//--- hdl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // widths with a meaning
    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    // bit 6 carries the subcode
    typedef logic [6:0]  ecode_t;
    typedef logic [12:0] int_vec_t;
    typedef logic [7:0]  hw_int_t;

    // software write port
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t mask;
        csr_data_t data;
    } csr_wr_t;

    // exception events from the pipeline
    typedef struct packed {
        logic      store;
        logic      restore;
        logic      ecode_we;
        ecode_t    ecode;
        logic      era_we;
        csr_data_t era;
    } exc_evt_t;

    typedef struct packed {
        csr_data_t crmd;
        csr_data_t prmd;
        csr_data_t ecfg;
        csr_data_t estat;
        csr_data_t era;
        csr_data_t eentry;
    } exc_view_t;

    typedef struct packed {
        csr_data_t tid;
        csr_data_t tcfg;
        csr_data_t tval;
    } timer_view_t;

    // bitwise masked update of one register word
    function automatic csr_data_t csr_merge(csr_data_t old, csr_data_t mask, csr_data_t data);
        return (old & ~mask) | (data & mask);
    endfunction

endpackage

`default_nettype wire

//--- hdl/csr_except_regs.sv
`default_nettype none

`include "csr_macros.svh"

module csr_except_regs (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire csr_pkg::csr_wr_t  wr,
    input  wire csr_pkg::exc_evt_t evt,
    input  wire csr_pkg::hw_int_t  hardware_int,
    input  wire logic              timer_int,
    output csr_pkg::exc_view_t     view,
    output csr_pkg::plv_t          plv,
    output logic [5:0]             ecode,
    output csr_pkg::csr_data_t     era_out,
    output csr_pkg::csr_data_t     eentry,
    output logic                   has_interrupt_cpu,
    output logic                   has_interrupt_idle
);

    import csr_pkg::*;

    csr_data_t crmd_q;
    csr_data_t prmd_q;
    csr_data_t ecfg_q;
    csr_data_t estat_q;
    csr_data_t era_q;
    csr_data_t eentry_q;
    csr_data_t estat_word;
    int_vec_t  is_vec;

    logic we_crmd;
    logic we_prmd;
    logic we_ecfg;
    logic we_estat;
    logic we_era;
    logic we_eentry;

    assign we_crmd   = wr.en && (wr.addr == `CSR_CRMD);
    assign we_prmd   = wr.en && (wr.addr == `CSR_PRMD);
    assign we_ecfg   = wr.en && (wr.addr == `CSR_ECFG);
    assign we_estat  = wr.en && (wr.addr == `CSR_ESTAT);
    assign we_era    = wr.en && (wr.addr == `CSR_ERA);
    assign we_eentry = wr.en && (wr.addr == `CSR_EENTRY);

    ////////////////////////////////////////////////////////////
    // mode registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd_q <= '0;
        end else if (evt.restore) begin
            crmd_q[`CRMD_PLV] <= prmd_q[`PRMD_PPLV];
            crmd_q[`CRMD_IE]  <= prmd_q[`PRMD_PIE];
        end else if (evt.store) begin
            // exception entry drops to kernel with interrupts off
            crmd_q[`CRMD_PLV] <= '0;
            crmd_q[`CRMD_IE]  <= 1'b0;
        end else if (we_crmd) begin
            crmd_q <= csr_merge(crmd_q, wr.mask & `CSR_CRMD_WMASK, wr.data);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prmd_q <= '0;
        end else if (evt.store) begin
            prmd_q[`PRMD_PPLV] <= crmd_q[`CRMD_PLV];
            prmd_q[`PRMD_PIE]  <= crmd_q[`CRMD_IE];
        end else if (we_prmd) begin
            // same layout as crmd
            prmd_q <= csr_merge(prmd_q, wr.mask & `CSR_CRMD_WMASK, wr.data);
        end
    end

    ////////////////////////////////////////////////////////////
    // exception config and status
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecfg_q <= '0;
        end else if (we_ecfg) begin
            ecfg_q <= csr_merge(ecfg_q, wr.mask & `CSR_ECFG_WMASK, wr.data);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            estat_q <= '0;
        end else if (evt.ecode_we) begin
            estat_q[`ESTAT_ECODE] <= evt.ecode[5:0];
            // subcode only for non-interrupt causes
            estat_q[`ESTAT_ESUBCODE] <= (|evt.ecode[5:0]) ? {8'b0, evt.ecode[6]} : 9'b0;
        end else if (we_estat) begin
            estat_q <= csr_merge(estat_q, wr.mask & `CSR_ESTAT_WMASK, wr.data);
        end
    end

    // sw bits, hw lines, timer; ipi and bit 10 tied low
    always_comb begin
        is_vec = '0;
        is_vec[1:0] = estat_q[1:0];
        is_vec[9:2] = hardware_int;
        is_vec[`CSR_IS_TI] = timer_int;
    end

    always_comb begin
        estat_word = estat_q;
        estat_word[`ESTAT_IS] = is_vec;
    end

    ////////////////////////////////////////////////////////////
    // return address and entry base
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            era_q <= '0;
        end else if (evt.era_we) begin
            era_q <= evt.era;
        end else if (we_era) begin
            era_q <= csr_merge(era_q, wr.mask, wr.data);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            eentry_q <= '0;
        end else if (we_eentry) begin
            eentry_q <= csr_merge(eentry_q, wr.mask & `CSR_EENTRY_WMASK, wr.data);
        end
    end

    assign view.crmd   = crmd_q;
    assign view.prmd   = prmd_q;
    assign view.ecfg   = ecfg_q;
    assign view.estat  = estat_word;
    assign view.era    = era_q;
    assign view.eentry = eentry_q;

    assign plv     = crmd_q[`CRMD_PLV];
    assign ecode   = estat_q[`ESTAT_ECODE];
    assign era_out = era_q;
    assign eentry  = {eentry_q[`EENTRY_VA], 6'b0};

    assign has_interrupt_cpu  = crmd_q[`CRMD_IE] & (|(ecfg_q[`ECFG_LIE] & is_vec));
    assign has_interrupt_idle = |is_vec;

endmodule

`default_nettype wire

//--- hdl/csr_timer.sv
`default_nettype none

`include "csr_macros.svh"

module csr_timer (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire csr_pkg::csr_wr_t wr,
    output csr_pkg::timer_view_t  view,
    output csr_pkg::csr_data_t    tid,
    output logic                  timer_int
);

    import csr_pkg::*;

    csr_data_t tid_q;
    csr_data_t tcfg_q;
    csr_data_t tval_q;
    logic      reload;
    logic      time_out;
    logic      we_tid;
    logic      we_tcfg;
    logic      clr_ti;

    assign we_tid  = wr.en && (wr.addr == `CSR_TID);
    assign we_tcfg = wr.en && (wr.addr == `CSR_TCFG);
    assign clr_ti  = wr.en && (wr.addr == `CSR_TICLR)
                     && wr.mask[`TICLR_CLR] && wr.data[`TICLR_CLR];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tid_q <= '0;
        end else if (we_tid) begin
            tid_q <= csr_merge(tid_q, wr.mask, wr.data);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcfg_q <= '0;
        end else if (we_tcfg) begin
            tcfg_q <= csr_merge(tcfg_q, wr.mask, wr.data);
        end
    end

    // any tcfg write restarts the count
    always_ff @(posedge clk) begin
        if (!rstn) begin
            reload <= 1'b0;
        end else begin
            reload <= we_tcfg && (|wr.mask);
        end
    end

    ////////////////////////////////////////////////////////////
    // count-down value
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tval_q   <= '0;
            time_out <= 1'b0;
        end else if (reload || (tval_q == '0)) begin
            time_out <= 1'b0;
            // low bits 01 so that initval 0 still fires
            if (reload || tcfg_q[`TCFG_PERIODIC]) begin
                tval_q <= {tcfg_q[`TCFG_INITVAL], 2'b01};
            end
        end else if (tcfg_q[`TCFG_EN]) begin
            tval_q   <= tval_q - 32'd1;
            time_out <= (tval_q == 32'd1);
        end else begin
            time_out <= 1'b0;
        end
    end

    // clear wins over a simultaneous time-out
    always_ff @(posedge clk) begin
        if (!rstn) begin
            timer_int <= 1'b0;
        end else if (clr_ti) begin
            timer_int <= 1'b0;
        end else if (time_out) begin
            timer_int <= 1'b1;
        end
    end

    assign view.tid  = tid_q;
    assign view.tcfg = tcfg_q;
    assign view.tval = tval_q;
    assign tid       = tid_q;

endmodule

`default_nettype wire

//--- hdl/csr_save_regs.sv
`default_nettype none

`include "csr_macros.svh"

module csr_save_regs (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire csr_pkg::csr_wr_t wr,
    output csr_pkg::csr_data_t    save0,
    output csr_pkg::csr_data_t    save1,
    output csr_pkg::csr_data_t    save2,
    output csr_pkg::csr_data_t    save3
);

    import csr_pkg::*;

    localparam csr_addr_t SAVE_BASE = `CSR_SAVE0;

    csr_data_t save_q [4];
    logic      we_save;

    // four consecutive addresses, low two bits pick the word
    assign we_save = wr.en && (wr.addr[13:2] == SAVE_BASE[13:2]);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (we_save) begin
            save_q[wr.addr[1:0]] <= csr_merge(save_q[wr.addr[1:0]], wr.mask, wr.data);
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

`default_nettype wire

//--- hdl/csr_read_mux.sv
`default_nettype none

`include "csr_macros.svh"

module csr_read_mux (
    input  wire csr_pkg::csr_addr_t   raddr_a,
    input  wire csr_pkg::csr_addr_t   raddr_b,
    input  wire csr_pkg::exc_view_t   exc,
    input  wire csr_pkg::timer_view_t tmr,
    input  wire csr_pkg::csr_data_t   save0,
    input  wire csr_pkg::csr_data_t   save1,
    input  wire csr_pkg::csr_data_t   save2,
    input  wire csr_pkg::csr_data_t   save3,
    output csr_pkg::csr_data_t        rdata_a,
    output csr_pkg::csr_data_t        rdata_b
);

    import csr_pkg::*;

    // one decoder shared by both ports
    function automatic csr_data_t read_word(csr_addr_t addr);
        csr_data_t word;
        case (addr)
            `CSR_CRMD:   word = exc.crmd;
            `CSR_PRMD:   word = exc.prmd;
            `CSR_ECFG:   word = exc.ecfg;
            `CSR_ESTAT:  word = exc.estat;
            `CSR_ERA:    word = exc.era;
            `CSR_EENTRY: word = exc.eentry;
            `CSR_SAVE0:  word = save0;
            `CSR_SAVE1:  word = save1;
            `CSR_SAVE2:  word = save2;
            `CSR_SAVE3:  word = save3;
            `CSR_TID:    word = tmr.tid;
            `CSR_TCFG:   word = tmr.tcfg;
            `CSR_TVAL:   word = tmr.tval;
            // write-only clear
            `CSR_TICLR:  word = '0;
            default:     word = '0;
        endcase
        return word;
    endfunction

    assign rdata_a = read_word(raddr_a);
    assign rdata_b = read_word(raddr_b);

endmodule

`default_nettype wire

//--- hdl/csr_top.sv
`default_nettype none

module csr_top (
    input  wire logic               clk,
    input  wire logic               rstn,
    // software write port
    input  wire csr_pkg::csr_wr_t   wr,
    // pipeline events
    input  wire csr_pkg::exc_evt_t  evt,
    // software read ports
    input  wire csr_pkg::csr_addr_t raddr_a,
    input  wire csr_pkg::csr_addr_t raddr_b,
    output csr_pkg::csr_data_t      rdata_a,
    output csr_pkg::csr_data_t      rdata_b,
    input  wire csr_pkg::hw_int_t   hardware_int,
    // machine state
    output csr_pkg::plv_t           plv,
    output logic [5:0]              ecode,
    output csr_pkg::csr_data_t      era_out,
    output csr_pkg::csr_data_t      eentry,
    output csr_pkg::csr_data_t      tid,
    output logic                    has_interrupt_cpu,
    output logic                    has_interrupt_idle
);

    import csr_pkg::*;

    exc_view_t   exc_view;
    timer_view_t tmr_view;
    csr_data_t   save0;
    csr_data_t   save1;
    csr_data_t   save2;
    csr_data_t   save3;
    logic        timer_int;

    csr_except_regs u_except (
        .clk                (clk),
        .rstn               (rstn),
        .wr                 (wr),
        .evt                (evt),
        .hardware_int       (hardware_int),
        .timer_int          (timer_int),
        .view               (exc_view),
        .plv                (plv),
        .ecode              (ecode),
        .era_out            (era_out),
        .eentry             (eentry),
        .has_interrupt_cpu  (has_interrupt_cpu),
        .has_interrupt_idle (has_interrupt_idle)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr),
        .view      (tmr_view),
        .tid       (tid),
        .timer_int (timer_int)
    );

    csr_save_regs u_save (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (wr),
        .save0 (save0),
        .save1 (save1),
        .save2 (save2),
        .save3 (save3)
    );

    csr_read_mux u_rmux (
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .exc     (exc_view),
        .tmr     (tmr_view),
        .save0   (save0),
        .save1   (save1),
        .save2   (save2),
        .save3   (save3),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rstn
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_csr.sv
`default_nettype none

`include "csr_macros.svh"

module tb_csr;

    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    localparam int          RESET_TIMEOUT = 40;
    localparam logic [31:0] SEED          = 32'h402d_72dc;

    localparam csr_addr_t WR_ADDRS [10] = '{
        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_ERA,
        `CSR_EENTRY, `CSR_ECFG, `CSR_CRMD, `CSR_PRMD, `CSR_TID
    };
    localparam csr_addr_t ALL_ADDRS [14] = '{
        `CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA, `CSR_EENTRY,
        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
        `CSR_TID, `CSR_TCFG, `CSR_TVAL, `CSR_TICLR
    };

    logic       clk;
    logic       rstn;
    csr_wr_t    wr;
    exc_evt_t   evt;
    csr_addr_t  raddr_a;
    csr_addr_t  raddr_b;
    csr_data_t  rdata_a;
    csr_data_t  rdata_b;
    hw_int_t    hardware_int;
    plv_t       plv;
    logic [5:0] ecode;
    csr_data_t  era_out;
    csr_data_t  eentry;
    csr_data_t  tid;
    logic       has_interrupt_cpu;
    logic       has_interrupt_idle;
    logic       check_on;

    // register model
    csr_data_t m_crmd;
    csr_data_t m_prmd;
    csr_data_t m_ecfg;
    csr_data_t m_estat;
    csr_data_t m_era;
    csr_data_t m_eentry;
    csr_data_t m_tid;
    csr_data_t m_tcfg;
    csr_data_t m_save [4];

    tb_clock u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    csr_top dut (
        .clk                (clk),
        .rstn               (rstn),
        .wr                 (wr),
        .evt                (evt),
        .raddr_a            (raddr_a),
        .raddr_b            (raddr_b),
        .rdata_a            (rdata_a),
        .rdata_b            (rdata_b),
        .hardware_int       (hardware_int),
        .plv                (plv),
        .ecode              (ecode),
        .era_out            (era_out),
        .eentry             (eentry),
        .tid                (tid),
        .has_interrupt_cpu  (has_interrupt_cpu),
        .has_interrupt_idle (has_interrupt_idle)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic csr_data_t replace_bits(csr_data_t old, csr_data_t sel, csr_data_t data);
        csr_data_t word;
        for (int i = 0; i < 32; i++) begin
            word[i] = sel[i] ? data[i] : old[i];
        end
        return word;
    endfunction

    // sw bits and hw lines
    // timer flag stays low outside the timer phase
    function automatic int_vec_t expected_is();
        int_vec_t v;
        v = '0;
        v[1:0] = m_estat[1:0];
        v[9:2] = hardware_int;
        return v;
    endfunction

    function automatic logic expected_cpu_int();
        return m_crmd[`CRMD_IE] & (|(m_ecfg[12:0] & expected_is()));
    endfunction

    function automatic csr_data_t expected_read(csr_addr_t addr);
        csr_data_t word;
        case (addr)
            `CSR_CRMD:   word = m_crmd;
            `CSR_PRMD:   word = m_prmd;
            `CSR_ECFG:   word = m_ecfg;
            `CSR_ESTAT:  word = {m_estat[31:13], expected_is()};
            `CSR_ERA:    word = m_era;
            `CSR_EENTRY: word = m_eentry;
            `CSR_SAVE0:  word = m_save[0];
            `CSR_SAVE1:  word = m_save[1];
            `CSR_SAVE2:  word = m_save[2];
            `CSR_SAVE3:  word = m_save[3];
            `CSR_TID:    word = m_tid;
            `CSR_TCFG:   word = m_tcfg;
            default:     word = '0;
        endcase
        return word;
    endfunction

    task automatic model_reset();
        m_crmd   = '0;
        m_prmd   = '0;
        m_ecfg   = '0;
        m_estat  = '0;
        m_era    = '0;
        m_eentry = '0;
        m_tid    = '0;
        m_tcfg   = '0;
        for (int i = 0; i < 4; i++) begin
            m_save[i] = '0;
        end
    endtask

    // restore, store, pipeline load, then software write
    task automatic model_apply(input csr_wr_t w, input exc_evt_t e);
        csr_data_t old_crmd;
        csr_data_t old_prmd;
        logic      sw;
        old_crmd = m_crmd;
        old_prmd = m_prmd;
        sw = w.en;
        if (e.restore) begin
            m_crmd[2:0] = old_prmd[2:0];
        end else if (e.store) begin
            m_crmd[2:0] = 3'b000;
        end else if (sw && w.addr == `CSR_CRMD) begin
            m_crmd = replace_bits(old_crmd, w.mask & `CSR_CRMD_WMASK, w.data);
        end
        if (e.store) begin
            m_prmd[2:0] = old_crmd[2:0];
        end else if (sw && w.addr == `CSR_PRMD) begin
            m_prmd = replace_bits(old_prmd, w.mask & `CSR_CRMD_WMASK, w.data);
        end
        if (e.ecode_we) begin
            m_estat[21:16] = e.ecode[5:0];
            m_estat[30:22] = (e.ecode[5:0] != 6'b0) ? {8'h00, e.ecode[6]} : 9'h000;
        end else if (sw && w.addr == `CSR_ESTAT) begin
            m_estat = replace_bits(m_estat, w.mask & `CSR_ESTAT_WMASK, w.data);
        end
        if (e.era_we) begin
            m_era = e.era;
        end else if (sw && w.addr == `CSR_ERA) begin
            m_era = replace_bits(m_era, w.mask, w.data);
        end
        if (sw && w.addr == `CSR_ECFG) begin
            m_ecfg = replace_bits(m_ecfg, w.mask & `CSR_ECFG_WMASK, w.data);
        end
        if (sw && w.addr == `CSR_EENTRY) begin
            m_eentry = replace_bits(m_eentry, w.mask & `CSR_EENTRY_WMASK, w.data);
        end
        if (sw && w.addr == `CSR_TID) begin
            m_tid = replace_bits(m_tid, w.mask, w.data);
        end
        if (sw && w.addr == `CSR_TCFG) begin
            m_tcfg = replace_bits(m_tcfg, w.mask, w.data);
        end
        if (sw && w.addr >= `CSR_SAVE0 && w.addr <= `CSR_SAVE3) begin
            m_save[w.addr[1:0]] = replace_bits(m_save[w.addr[1:0]], w.mask, w.data);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////
    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped after a failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h",
                                      name, got, exp));
        end
    endtask

    // mid low phase after the falling-edge drive has settled
    always begin
        @(negedge clk);
        #5;
        if (check_on) begin
            check_value("rdata_a", rdata_a, expected_read(raddr_a));
            check_value("rdata_b", rdata_b, expected_read(raddr_b));
            check_value("plv", {30'b0, plv}, {30'b0, m_crmd[1:0]});
            check_value("ecode", {26'b0, ecode}, {26'b0, m_estat[21:16]});
            check_value("era_out", era_out, m_era);
            check_value("eentry", eentry, m_eentry);
            check_value("tid", tid, m_tid);
            check_value("has_interrupt_cpu", {31'b0, has_interrupt_cpu},
                        {31'b0, expected_cpu_int()});
            check_value("has_interrupt_idle", {31'b0, has_interrupt_idle},
                        {31'b0, |expected_is()});
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////
    task automatic drive_cycle(input csr_wr_t w, input exc_evt_t e);
        @(negedge clk);
        wr  = w;
        evt = e;
        @(negedge clk);
        wr  = '0;
        evt = '0;
        model_apply(w, e);
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_data_t mask, input csr_data_t data);
        csr_wr_t  w;
        exc_evt_t e;
        w.en   = 1'b1;
        w.addr = addr;
        w.mask = mask;
        w.data = data;
        e = '0;
        drive_cycle(w, e);
    endtask

    task automatic read_pair(input csr_addr_t a, input csr_addr_t b);
        @(negedge clk);
        raddr_a = a;
        raddr_b = b;
        #5;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rstn !== 1'b1 && n < RESET_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rstn !== 1'b1) begin
            stop_on_failure("reset was never released");
        end
    endtask

    task automatic wait_timer_int(input int limit, output csr_data_t first_tval,
                                  output csr_data_t last_tval);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        first_tval = '0;
        last_tval = '0;
        while (!seen && n < limit) begin
            read_pair(`CSR_TVAL, `CSR_ESTAT);
            if (rdata_a != '0) begin
                if (first_tval == '0) begin
                    first_tval = rdata_a;
                end
                last_tval = rdata_a;
            end
            seen = rdata_b[`CSR_IS_TI];
            n++;
        end
        if (!seen) begin
            stop_on_failure("timeout while waiting for the timer interrupt in ESTAT");
        end
    endtask

    task automatic clear_timer_int();
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        read_pair(`CSR_TVAL, `CSR_ESTAT);
        check_value("estat.ti", {31'b0, rdata_b[`CSR_IS_TI]}, 32'h0);
        check_value("has_interrupt_idle", {31'b0, has_interrupt_idle}, 32'h0);
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////
    task automatic run_reset_test();
        for (int i = 0; i < 14; i++) begin
            read_pair(ALL_ADDRS[i], ALL_ADDRS[13 - i]);
        end
    endtask

    task automatic run_masked_writes();
        csr_addr_t addr;
        int        idx;
        for (int i = 0; i < 40; i++) begin
            idx = int'($urandom_range(9, 0));
            addr = WR_ADDRS[idx];
            write_csr(addr, $urandom(), $urandom());
            read_pair(addr, addr);
        end
        write_csr(14'h3ff, 32'hffff_ffff, $urandom());
        read_pair(14'h3ff, `CSR_TICLR);
        read_pair(14'h002, 14'h043);
    endtask

    task automatic run_exception_tests();
        csr_wr_t     w;
        exc_evt_t    e;
        logic [31:0] rnd;
        write_csr(`CSR_CRMD, 32'h7, 32'h7);
        write_csr(`CSR_PRMD, 32'h7, 32'h2);
        e = '0;
        e.store = 1'b1;
        w = '0;
        drive_cycle(w, e);
        read_pair(`CSR_CRMD, `CSR_PRMD);
        e = '0;
        e.restore = 1'b1;
        drive_cycle(w, e);
        read_pair(`CSR_CRMD, `CSR_PRMD);
        // store beats a write to crmd in the same cycle
        w.en = 1'b1;
        w.addr = `CSR_CRMD;
        w.mask = 32'hffff_ffff;
        w.data = 32'h0000_0007;
        e = '0;
        e.store = 1'b1;
        drive_cycle(w, e);
        read_pair(`CSR_CRMD, `CSR_PRMD);
        for (int i = 0; i < 10; i++) begin
            rnd = $urandom();
            e = '0;
            e.ecode_we = 1'b1;
            e.ecode = (i == 0) ? 7'h40 : ((i == 1) ? 7'h4a : rnd[6:0]);
            drive_cycle('0, e);
            read_pair(`CSR_ESTAT, `CSR_ESTAT);
        end
        w.en = 1'b1;
        w.addr = `CSR_ERA;
        w.mask = 32'hffff_ffff;
        w.data = $urandom();
        e = '0;
        e.era_we = 1'b1;
        e.era = $urandom();
        drive_cycle(w, e);
        read_pair(`CSR_ERA, `CSR_ERA);
    endtask

    task automatic run_interrupt_tests();
        logic [31:0] rnd;
        for (int i = 0; i < 24; i++) begin
            write_csr(`CSR_ECFG, $urandom(), $urandom());
            write_csr(`CSR_CRMD, 32'h4, $urandom());
            write_csr(`CSR_ESTAT, $urandom(), $urandom());
            rnd = $urandom();
            @(negedge clk);
            hardware_int = rnd[7:0];
            read_pair(`CSR_ESTAT, `CSR_ECFG);
        end
        @(negedge clk);
        hardware_int = '0;
    endtask

    task automatic run_timer_tests();
        int        iv;
        int        limit;
        csr_data_t first_tval;
        csr_data_t last_tval;
        // only the timer flag drives the idle line from here on
        write_csr(`CSR_ESTAT, 32'h3, 32'h0);
        // explicit checks while the timer runs
        check_on = 1'b0;
        iv = int'($urandom_range(8, 3));
        limit = iv * 4 + 8;
        // one-shot
        write_csr(`CSR_TCFG, 32'hffff_ffff, {iv[29:0], 2'b01});
        wait_timer_int(limit, first_tval, last_tval);
        check_value("tval", first_tval, {iv[29:0], 2'b01});
        if (!(last_tval < first_tval)) begin
            stop_on_failure("TVAL did not count down between two reads");
        end
        check_value("has_interrupt_idle", {31'b0, has_interrupt_idle}, 32'h1);
        clear_timer_int();
        for (int i = 0; i < 8; i++) begin
            read_pair(`CSR_TVAL, `CSR_ESTAT);
            check_value("tval", rdata_a, 32'h0);
            check_value("estat.ti", {31'b0, rdata_b[`CSR_IS_TI]}, 32'h0);
        end
        // periodic
        write_csr(`CSR_TCFG, 32'hffff_ffff, {iv[29:0], 2'b11});
        wait_timer_int(limit, first_tval, last_tval);
        clear_timer_int();
        wait_timer_int(limit, first_tval, last_tval);
        clear_timer_int();
        write_csr(`CSR_TCFG, 32'hffff_ffff, 32'h0);
    endtask

    initial begin
        wr = '0;
        evt = '0;
        raddr_a = '0;
        raddr_b = '0;
        hardware_int = '0;
        check_on = 1'b0;
        model_reset();
        void'($urandom(SEED));
        wait_reset_release();
        check_on = 1'b1;
        run_reset_test();
        run_masked_writes();
        run_exception_tests();
        run_interrupt_tests();
        run_timer_tests();
        @(negedge clk);
        #6;
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_except_regs.sv
hdl/csr_timer.sv
hdl/csr_save_regs.sv
hdl/csr_read_mux.sv
hdl/csr_top.sv
tests/tb_clock.sv
tests/tb_csr.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_csr
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
